//--- uart_lite.f
design/uart_pkg.sv
design/byte_fifo_if.sv
design/byte_fifo.sv
design/uart_baud.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_regs.sv
design/uart_lite.sv
bench/tb_clkgen.sv
bench/uart_lite_assert.sv
bench/tb_uart_lite.sv

//--- Makefile
TOP := tb_uart_lite

all: run

run:
	verilator --binary --timing --assert -f uart_lite.f --top-module $(TOP) -o sim
	./obj_dir/sim | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then exit 1; fi
	@grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only --timing --assert -f uart_lite.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

//--- bench/uart_golden.txt
# op test addr data mask; test is decimal, the rest hex; written for fifo_aw 2
# W write, R read under mask, E wait data frames, I compare o_irq, D end of test
W 1 2 00060001 00000000
W 1 3 00030001 00000000
W 1 4 00000002 00000000
W 1 6 00000004 00000000
R 1 2 00060001 00070001
R 1 3 00030001 00070001
R 1 4 00000002 00000003
R 1 6 00000004 ffffffff
D 1 0 00000000 00000000
W 2 0 00000041 00000000
W 2 0 000000a5 00000000
W 2 0 0000003c 00000000
E 2 0 00000004 00000000
R 2 1 00000041 800000ff
R 2 1 000000a5 800000ff
R 2 1 0000003c 800000ff
R 2 1 80000000 80000000
D 2 0 00000000 00000000
W 3 2 00060000 00000000
W 3 0 00000011 00000000
W 3 0 00000022 00000000
W 3 0 00000033 00000000
W 3 0 00000044 00000000
R 3 0 80000000 80000000
W 3 2 00060001 00000000
E 3 0 00000004 00000000
R 3 1 00000011 800000ff
R 3 1 00000022 800000ff
R 3 1 00000033 800000ff
R 3 1 80000000 80000000
D 3 0 00000000 00000000
W 4 3 00010001 00000000
W 4 0 00000061 00000000
E 4 0 00000002 00000000
I 4 0 00000000 00000001
W 4 0 00000062 00000000
E 4 0 00000002 00000000
I 4 0 00000001 00000001
W 4 5 00000000 00000000
R 4 1 00000061 800000ff
R 4 1 00000062 800000ff
I 4 0 00000000 00000001
D 4 0 00000000 00000000
W 5 2 00020000 00000000
W 5 4 00000001 00000000
R 5 4 00000001 00000003
I 5 0 00000001 00000001
W 5 5 00000000 00000000
I 5 0 00000000 00000001
R 5 5 00000000 00000003
I 5 0 00000001 00000001
D 5 0 00000000 00000000

//--- bench/tb_uart_lite.sv
// Golden data expects fifo_aw 2 and is opened relative to the project root
module tb_uart_lite
    import uart_pkg::*;
();
    localparam int fifo_aw = 2;
    localparam int max_ops = 128;

    logic        clk;
    logic        nrst;
    logic        req_valid;
    logic        req_write;
    reg_idx_t    req_addr;
    logic [31:0] req_wdata;
    logic        resp_valid;
    logic [31:0] resp_rdata;
    logic        td;                    // Looped back into i_rd
    logic        irq;

    logic [7:0]  op_code [max_ops];
    int          op_test [max_ops];
    logic [31:0] op_addr [max_ops];
    logic [31:0] op_data [max_ops];
    logic [31:0] op_mask [max_ops];
    int          n_ops;
    int          cycles;
    int          limit;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    logic [31:0] scaler;

    tb_clkgen i_clkgen (.o_clk(clk), .o_nrst(nrst));

    uart_lite #(.fifo_aw(fifo_aw)) i_uart_lite (
        .i_clk(clk), .i_nrst(nrst), .i_req_valid(req_valid), .i_req_write(req_write),
        .i_req_addr(req_addr), .i_req_wdata(req_wdata), .o_resp_valid(resp_valid),
        .o_resp_rdata(resp_rdata), .i_rd(td), .o_td(td), .o_irq(irq)
    );

    task automatic load_golden();
        int          fd;
        int          got;
        int          sum;
        string       line;
        logic [7:0]  c;
        int          t;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] m;
        logic [31:0] run_scaler;
        sum        = 0;
        run_scaler = '0;
        fd = $fopen("bench/uart_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/uart_golden.txt");
            tests_failed++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") continue;
            got = $sscanf(line, "%c %d %h %h %h", c, t, a, d, m);
            if (got != 5 || n_ops == max_ops) begin
                $display("golden line not understood: %s", line);
                tests_failed++;
                continue;
            end
            op_code[n_ops] = c;
            op_test[n_ops] = t;
            op_addr[n_ops] = a;
            op_data[n_ops] = d;
            op_mask[n_ops] = m;
            n_ops++;
            if (c == "W" || c == "R") sum += 4;
            if (c == "W" && a[2:0] == reg_scaler) run_scaler = d;
            if (c == "E") sum += 20 * int'(run_scaler) * int'(d);   // Frame is 20 scaler clocks
        end
        $fclose(fd);
        limit = 12 + (sum * 3) / 2;
    endtask

    // One request, then wait for its response
    task automatic bus_access(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = reg_idx_t'(addr[2:0]);
        req_wdata = wdata;
        @(posedge clk);
        #5;
        req_valid = 1'b0;
        while (!resp_valid) begin
            @(posedge clk);
            #5;
        end
        rdata = resp_rdata;
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] got, input logic [31:0] mask);
        assert ((got & mask) == (exp & mask)) else begin
            $display("error: %0t %s expected %h got %h", $time, name, exp & mask, got & mask);
            test_errors++;
        end
    endtask

    task automatic end_test(input int num);
        if (test_errors == 0) begin
            $display("test %0d passed", num);
            tests_passed++;
        end else begin
            $display("test %0d failed with %0d errors", num, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("run stopped at the cycle limit of %0d", limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] rdata;
        int          i;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = reg_txdata;
        req_wdata = '0;
        scaler    = '0;
        load_golden();
        @(posedge nrst);
        @(posedge clk);
        #5;
        for (i = 0; i < n_ops; i++) begin
            case (op_code[i])
                "W": begin
                    bus_access(1'b1, op_addr[i], op_data[i], rdata);
                    if (op_addr[i][2:0] == reg_scaler) scaler = op_data[i];
                end
                "R": begin
                    bus_access(1'b0, op_addr[i], '0, rdata);
                    check_word("o_resp_rdata", op_data[i], rdata, op_mask[i]);
                end
                "E": begin
                    repeat (20 * int'(scaler) * int'(op_data[i])) @(posedge clk);
                    #5;
                end
                "I": check_word("o_irq", op_data[i], {31'd0, irq}, op_mask[i]);
                "D": end_test(op_test[i]);
                default: begin
                    $display("unknown operation %c in golden entry %0d", op_code[i], i);
                    test_errors++;
                end
            endcase
        end
        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && test_errors == 0 && tests_passed > 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- bench/uart_lite_assert.sv
// Bound into uart_lite; the enable pair is taken from inside the register block
module uart_lite_assert
    import uart_pkg::*;
(
    input logic       i_clk,
    input logic       i_nrst,
    input logic       i_req_valid,
    input logic       i_req_write,
    input reg_idx_t   i_req_addr,
    input logic       i_resp_valid,
    input logic [1:0] i_ie,
    input logic       i_irq,
    input logic       i_tx_idle,
    input logic       i_td
);
    logic ip_wr;

    assign ip_wr = i_req_valid && i_req_write && (i_req_addr == reg_ip);

    resp_follows_req: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_resp_valid == $past(i_req_valid))
        else $error("response valid is not the request delayed by one cycle");

    // Pending bits lag the enables by one cycle
    irq_gated: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (($past(i_ie) == 2'b00) && !$past(ip_wr)) |-> !i_irq)
        else $error("interrupt raised with both enables off");

    idle_line_high: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_tx_idle |-> i_td)
        else $error("transmit line low while the transmitter is idle");

endmodule

bind uart_lite uart_lite_assert i_assert (
    .i_clk(i_clk), .i_nrst(i_nrst), .i_req_valid(i_req_valid), .i_req_write(i_req_write),
    .i_req_addr(i_req_addr), .i_resp_valid(o_resp_valid),
    .i_ie({i_regs.rx_ie, i_regs.tx_ie}), .i_irq(o_irq), .i_tx_idle(tx_idle), .i_td(o_td)
);

//--- bench/tb_clkgen.sv
// Free running clock of period 40; reset is held low for the first 10 rising edges
module tb_clkgen (
    output logic o_clk,
    output logic o_nrst
);
    initial begin
        o_clk = 1'b0;
        forever #20 o_clk = !o_clk;
    end

    initial begin
        o_nrst = 1'b0;
        repeat (10) @(posedge o_clk);
        #5 o_nrst = 1'b1;                   // Released with the other inputs
    end

endmodule

//--- design/uart_lite.sv
// No back-pressure; each request gets its response exactly one cycle later
module uart_lite
    import uart_pkg::*;
#(
    parameter int fifo_aw = 4
) (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_req_valid,
    input  logic        i_req_write,
    input  reg_idx_t    i_req_addr,
    input  logic [31:0] i_req_wdata,
    output logic        o_resp_valid,
    output logic [31:0] o_resp_rdata,
    input  logic        i_rd,
    output logic        o_td,
    output logic        o_irq
);
    logic        tx_ena;
    logic        rx_ena;
    logic [31:0] scaler;
    logic        rise;
    logic        fall;
    logic        tx_idle;
    logic        rx_idle;

    byte_fifo_if #(.fifo_aw(fifo_aw)) tx_q ();
    byte_fifo_if #(.fifo_aw(fifo_aw)) rx_q ();

    uart_regs #(.fifo_aw(fifo_aw)) i_regs (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_req_valid(i_req_valid),
        .i_req_write(i_req_write), .i_req_addr(i_req_addr), .i_req_wdata(i_req_wdata),
        .o_resp_valid(o_resp_valid), .o_resp_rdata(o_resp_rdata),
        .tx_q(tx_q.writer), .rx_q(rx_q.reader), .o_tx_ena(tx_ena), .o_rx_ena(rx_ena),
        .o_scaler(scaler), .o_irq(o_irq)
    );

    uart_baud i_baud (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_scaler(scaler), .i_tx_idle(tx_idle),
        .i_rx_idle(rx_idle), .i_tx_empty(tx_q.empty), .i_rd(i_rd),
        .o_rise(rise), .o_fall(fall)
    );

    byte_fifo #(.fifo_aw(fifo_aw)) i_tx_fifo (.i_clk(i_clk), .i_nrst(i_nrst), .q(tx_q.fifo));
    byte_fifo #(.fifo_aw(fifo_aw)) i_rx_fifo (.i_clk(i_clk), .i_nrst(i_nrst), .q(rx_q.fifo));

    uart_tx i_tx (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_ena(tx_ena), .i_rise(rise),
        .q(tx_q.reader), .o_tx_idle(tx_idle), .o_td(o_td)
    );

    uart_rx i_rx (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_ena(rx_ena), .i_fall(fall), .i_rd(i_rd),
        .q(rx_q.writer), .o_rx_idle(rx_idle)
    );

endmodule

//--- design/uart_regs.sv
// Pending bits follow the FIFO rules each cycle so a write to ip lasts one cycle only
module uart_regs
    import uart_pkg::*;
#(
    parameter int fifo_aw = 4
) (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_req_valid,
    input  logic        i_req_write,
    input  reg_idx_t    i_req_addr,
    input  logic [31:0] i_req_wdata,
    output logic        o_resp_valid,
    output logic [31:0] o_resp_rdata,
    byte_fifo_if.writer tx_q,
    byte_fifo_if.reader rx_q,
    output logic        o_tx_ena,
    output logic        o_rx_ena,
    output logic [31:0] o_scaler,
    output logic        o_irq
);
    uart_word_u wr;
    uart_word_u rd;
    logic [2:0] tx_thresh;
    logic [2:0] rx_thresh;
    logic       tx_ie;
    logic       rx_ie;
    logic       tx_ip;
    logic       rx_ip;
    logic       wr_en;
    logic       tx_low;
    logic       rx_high;

    assign wr             = i_req_wdata;
    assign wr_en          = i_req_valid && i_req_write;
    assign tx_low         = tx_q.count < fifo_aw'(tx_thresh);
    assign rx_high        = rx_q.count > fifo_aw'(rx_thresh);
    assign tx_q.push      = wr_en && (i_req_addr == reg_txdata);
    assign tx_q.push_data = wr.data.chr;
    assign rx_q.pop       = i_req_valid && !i_req_write && (i_req_addr == reg_rxdata);
    assign o_irq          = tx_ip || rx_ip;

    always_comb begin
        rd = '0;
        case (i_req_addr)
            reg_txdata: rd.data.flag = tx_q.full;
            reg_rxdata: begin
                rd.data.flag = rx_q.empty;
                rd.data.chr  = rx_q.rd_data;
            end
            reg_txctrl: begin
                rd.ctrl.ena    = o_tx_ena;
                rd.ctrl.thresh = tx_thresh;
            end
            reg_rxctrl: begin
                rd.ctrl.ena    = o_rx_ena;
                rd.ctrl.thresh = rx_thresh;
            end
            reg_ie:     rd = 32'({rx_ie, tx_ie});
            reg_ip:     rd = 32'({rx_ip, tx_ip});
            reg_scaler: rd = o_scaler;
            default:    rd = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            {o_tx_ena, o_rx_ena, tx_ie, rx_ie, tx_ip, rx_ip} <= '0;
            tx_thresh    <= '0;
            rx_thresh    <= '0;
            o_scaler     <= '0;
            o_resp_valid <= 1'b0;
        end else begin
            o_resp_valid <= i_req_valid;
            tx_ip        <= tx_ie && tx_low;
            rx_ip        <= rx_ie && rx_high;
            if (wr_en) begin
                case (i_req_addr)
                    reg_txctrl: {o_tx_ena, tx_thresh} <= {wr.ctrl.ena, wr.ctrl.thresh};
                    reg_rxctrl: {o_rx_ena, rx_thresh} <= {wr.ctrl.ena, wr.ctrl.thresh};
                    reg_ie:     {rx_ie, tx_ie} <= i_req_wdata[1:0];
                    reg_ip:     {rx_ip, tx_ip} <= i_req_wdata[1:0];   // Overrides the rule
                    reg_scaler: o_scaler <= i_req_wdata;
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_req_valid) o_resp_rdata <= rd;
    end

endmodule

//--- design/uart_rx.sv
// Samples mid-bit on each fall; the stop bit is not checked and a full FIFO drops the byte
module uart_rx
    import uart_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_ena,
    input  logic        i_fall,
    input  logic        i_rd,
    byte_fifo_if.writer q,
    output logic        o_rx_idle
);
    line_state_t       state;
    logic [2:0]        bit_cnt;
    logic [data_w-1:0] shift;

    assign o_rx_idle   = (state == st_idle);
    assign q.push      = i_fall && (state == st_stop) && !q.full;
    assign q.push_data = shift;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state   <= st_idle;
            bit_cnt <= '0;
        end else if (i_fall) begin
            case (state)
                st_idle: begin
                    if (i_ena && !i_rd) begin   // Middle of start bit
                        state   <= st_data;
                        bit_cnt <= '0;
                    end
                end
                st_data: begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'(data_w - 1)) state <= st_stop;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge i_clk) begin
        if (i_fall && (state == st_data)) begin
            shift <= {i_rd, shift[data_w-1:1]};
        end
    end

endmodule

//--- design/uart_tx.sv
// 8N1 only; a queued byte starts on the rise that ends the previous stop bit
module uart_tx
    import uart_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_ena,
    input  logic        i_rise,
    byte_fifo_if.reader q,
    output logic        o_tx_idle,
    output logic        o_td
);
    line_state_t state;
    logic [9:0]  shift;
    logic        load;

    assign load      = i_rise && i_ena && !q.empty &&
                       ((state == st_idle) || (state == st_stop));
    assign q.pop     = load;
    assign o_tx_idle = (state == st_idle);
    assign o_td      = shift[0];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state <= st_idle;
            shift <= '1;                        // Line idles high
        end else if (load) begin
            shift <= {1'b1, q.rd_data, 1'b0};   // Stop, data, start
            state <= st_start;
        end else if (i_rise) begin
            case (state)
                st_start: begin
                    shift <= shift >> 1;
                    state <= st_data;
                end
                st_data: begin
                    shift <= shift >> 1;        // Zero fill leaves the stop bit on top
                    if (shift[9:1] == 9'd1) state <= st_stop;
                end
                st_stop: begin
                    state <= st_idle;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- design/uart_baud.sv
// Scaler 0 stops all strobes; one bit lasts 2*scaler clocks and strobes lag the wrap by a cycle
module uart_baud (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic [31:0] i_scaler,
    input  logic        i_tx_idle,
    input  logic        i_rx_idle,
    input  logic        i_tx_empty,
    input  logic        i_rd,
    output logic        o_rise,
    output logic        o_fall
);
    logic [31:0] cnt;
    logic        level;
    logic        hold;
    logic        wrap;

    // Quiet line and nothing to send
    assign hold = i_tx_idle && i_rx_idle && i_tx_empty && i_rd;
    assign wrap = cnt >= (i_scaler - 32'd1);

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            cnt    <= '0;
            level  <= 1'b1;
            o_rise <= 1'b0;
            o_fall <= 1'b0;
        end else begin
            o_rise <= 1'b0;
            o_fall <= 1'b0;
            if ((i_scaler == '0) || hold) begin
                cnt   <= '0;                    // Resync point
                level <= 1'b1;
            end else if (wrap) begin
                cnt    <= '0;
                level  <= !level;
                o_rise <= !level;
                o_fall <= level;
            end else begin
                cnt <= cnt + 32'd1;
            end
        end
    end

endmodule

//--- design/byte_fifo.sv
// Push while full and pop while empty are ignored; storage has no reset
module byte_fifo
    import uart_pkg::*;
#(
    parameter int fifo_aw = 4
) (
    input logic         i_clk,
    input logic         i_nrst,
    byte_fifo_if.fifo   q
);
    logic [data_w-1:0]  mem [2**fifo_aw];
    logic [fifo_aw-1:0] wr_ptr;
    logic [fifo_aw-1:0] rd_ptr;
    logic [fifo_aw-1:0] wr_nxt;
    logic               do_push;
    logic               do_pop;

    assign wr_nxt    = wr_ptr + 1'b1;
    assign q.full    = (wr_nxt == rd_ptr);     // One slot always left free
    assign q.empty   = (wr_ptr == rd_ptr);
    assign q.count   = wr_ptr - rd_ptr;
    assign q.rd_data = mem[rd_ptr];
    assign do_push   = q.push && !q.full;
    assign do_pop    = q.pop && !q.empty;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_nxt;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= q.push_data;
        end
    end

endmodule

//--- design/byte_fifo_if.sv
// Count is fifo_aw bits wide and the FIFO holds 2**fifo_aw - 1 bytes
interface byte_fifo_if
    import uart_pkg::*;
#(
    parameter int fifo_aw = 4
);
    logic               push;
    logic [data_w-1:0]  push_data;
    logic               pop;
    logic [data_w-1:0]  rd_data;       // Oldest byte
    logic               full;
    logic               empty;
    logic [fifo_aw-1:0] count;

    modport fifo   (input push, push_data, pop, output rd_data, full, empty, count);
    modport writer (output push, push_data, input full, count);
    modport reader (output pop, input rd_data, empty, count);

endinterface

//--- design/uart_pkg.sv
// Register map covers word indices 0 to 6 only and frames are fixed at 8N1
package uart_pkg;

    localparam int data_w = 8;

    typedef enum logic [2:0] {
        reg_txdata = 3'd0,
        reg_rxdata = 3'd1,
        reg_txctrl = 3'd2,
        reg_rxctrl = 3'd3,
        reg_ie     = 3'd4,
        reg_ip     = 3'd5,
        reg_scaler = 3'd6
    } reg_idx_t;

    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} line_state_t;

    typedef struct packed {
        logic [12:0] rsv_hi;
        logic [2:0]  thresh;    // FIFO level for the interrupt
        logic [14:0] rsv_lo;
        logic        ena;
    } ctrl_word_t;

    typedef struct packed {
        logic                flag;  // Full on txdata, empty on rxdata
        logic [30-data_w:0]  rsv;
        logic [data_w-1:0]   chr;
    } data_word_t;

    // Same bus word seen as control or as character
    typedef union packed {
        ctrl_word_t ctrl;
        data_word_t data;
    } uart_word_u;

endpackage
